// ==== src/dcache_defs.svh ====
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// byte address bits in use; the upper bus address bits stay zero.
`define DC_ADDR_BITS 16

`define DC_SETS 32
`define DC_SET_BITS 5

// one line holds a single 8-byte word.
`define DC_OFFSET_BITS 3

`define DC_TAG_BITS (`DC_ADDR_BITS - `DC_SET_BITS - `DC_OFFSET_BITS)

// victims waiting to be written back.
`define RETIRE_SIZE 4

// the bus response and the load return tag share this width.
`define BUS_TAG_BITS 4

`endif

// ==== src/dcache_pkg.sv ====
package dcache_pkg;

	`include "dcache_defs.svh"

	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_command_e;

	typedef enum logic {
		OP_LOAD  = 1'b0,
		OP_STORE = 1'b1
	} cpu_op_e;

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_EVICT,
		S_FETCH,
		S_WAIT,
		S_FILL
	} ctrl_state_e;

	typedef struct packed {
		cpu_op_e                  op;
		logic [`DC_ADDR_BITS-1:0] addr;
		logic [63:0]              wdata;
	} cpu_req_t;

	typedef struct packed {
		logic [63:0] rdata;
	} cpu_rsp_t;

	typedef struct packed {
		logic [63:0]             data;
		logic [`DC_TAG_BITS-1:0] tag;
		logic                    valid;
		logic                    dirty;
	} cache_line_t;

	typedef struct packed {
		cache_line_t             line;
		logic [`DC_SET_BITS-1:0] idx;
	} evict_t;

	typedef struct packed {
		logic [63:0] address;
		logic [63:0] data;
		logic        valid;
	} retire_entry_t;

	typedef struct packed {
		bus_command_e command;
		logic [63:0]  addr;
		logic [63:0]  data;
	} mem_req_t;

	typedef struct packed {
		logic [`BUS_TAG_BITS-1:0] response; // zero when the request was not taken.
		logic [63:0]              data;
		logic [`BUS_TAG_BITS-1:0] tag;      // zero when nothing returns this cycle.
	} mem_rsp_t;

endpackage

// ==== src/dcache_array.sv ====
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_array (
	input  logic                    clock,
	input  logic                    reset,
	input  logic [`DC_SET_BITS-1:0] rd_idx,
	output dcache_pkg::cache_line_t rd_line,
	input  logic                    wr_en,
	input  logic [`DC_SET_BITS-1:0] wr_idx,
	input  dcache_pkg::cache_line_t wr_line
);

	logic [63:0]             data_mem [`DC_SETS];
	logic [`DC_TAG_BITS-1:0] tag_mem [`DC_SETS];
	logic [`DC_SETS-1:0]     valid_bits;
	logic [`DC_SETS-1:0]     dirty_bits;

	always_comb begin
		rd_line.data  = data_mem[rd_idx];
		rd_line.tag   = tag_mem[rd_idx];
		rd_line.valid = valid_bits[rd_idx];
		rd_line.dirty = dirty_bits[rd_idx];
	end

	always_ff @(posedge clock) begin
		if (wr_en) begin
			data_mem[wr_idx] <= wr_line.data;
			tag_mem[wr_idx]  <= wr_line.tag;
		end
	end

	// data and tags mean nothing until the valid bit is set.
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (wr_en) begin
			valid_bits[wr_idx] <= wr_line.valid;
			dirty_bits[wr_idx] <= wr_line.dirty;
		end
	end

endmodule

// ==== src/retire_buffer.sv ====
`timescale 1ns/100ps
`include "dcache_defs.svh"

module retire_buffer (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     evict_valid,
	input  dcache_pkg::evict_t       evict,
	input  logic [63:0]              lookup_addr,
	output logic                     lookup_hit,
	output logic [63:0]              lookup_data,
	output dcache_pkg::mem_req_t     store_req,
	input  logic [`BUS_TAG_BITS-1:0] store_response,
	output logic                     full
);

	localparam int PTR_BITS = $clog2(`RETIRE_SIZE) + 1;

	dcache_pkg::retire_entry_t [`RETIRE_SIZE-1:0] queue;
	dcache_pkg::retire_entry_t [`RETIRE_SIZE-1:0] queue_next;
	logic [PTR_BITS-1:0] tail;
	logic [PTR_BITS-1:0] tail_next;

	logic send_request;
	logic accepted;
	logic enqueue;

	assign full     = (tail == PTR_BITS'(`RETIRE_SIZE));
	assign accepted = send_request && (store_response != '0);
	assign enqueue  = evict_valid && evict.line.dirty && !full;

	// the head entry is the oldest victim and is always the one on the bus.
	always_comb begin
		if (send_request) begin
			store_req.command = dcache_pkg::BUS_STORE;
			store_req.addr    = queue[0].address;
			store_req.data    = queue[0].data;
		end else begin
			store_req.command = dcache_pkg::BUS_NONE;
			store_req.addr    = '0;
			store_req.data    = '0;
		end
	end

	always_comb begin
		queue_next = queue;
		tail_next  = tail;

		if (accepted) begin
			queue_next = {dcache_pkg::retire_entry_t'('0), queue[`RETIRE_SIZE-1:1]};
			tail_next  = tail - 1'b1;
		end

		// a victim lands behind whatever survives this cycle's shift.
		if (enqueue) begin
			queue_next[tail_next[PTR_BITS-2:0]] = '{
				address: {{(64-`DC_ADDR_BITS){1'b0}}, evict.line.tag, evict.idx,
					{`DC_OFFSET_BITS{1'b0}}},
				data:    evict.line.data,
				valid:   1'b1
			};
			tail_next = tail_next + 1'b1;
		end
	end

	// higher slots are younger, so the last match in the scan wins.
	always_comb begin
		lookup_hit  = 1'b0;
		lookup_data = '0;
		for (int i = 0; i < `RETIRE_SIZE; i++) begin
			if (queue[i].valid && (queue[i].address == lookup_addr)) begin
				lookup_hit  = 1'b1;
				lookup_data = queue[i].data;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			queue        <= '0;
			tail         <= '0;
			send_request <= 1'b0;
		end else begin
			queue <= queue_next;
			tail  <= tail_next;
			if (send_request) begin
				send_request <= !accepted; // hold the store until memory takes it.
			end else begin
				send_request <= (tail != '0);
			end
		end
	end

endmodule

// ==== src/mem_bus_arbiter.sv ====
`timescale 1ns/100ps
`include "dcache_defs.svh"

module mem_bus_arbiter (
	input  logic                     clock,
	input  logic                     reset,
	input  dcache_pkg::mem_req_t     fill_req,
	input  dcache_pkg::mem_req_t     store_req,
	input  logic                     full,
	output logic [`BUS_TAG_BITS-1:0] fill_response,
	output logic [`BUS_TAG_BITS-1:0] store_response,
	output dcache_pkg::mem_req_t     mem_req,
	input  logic [`BUS_TAG_BITS-1:0] mem_rsp_response
);

	logic fill_active;
	logic store_active;
	logic sel_fill;
	logic hold;
	logic hold_fill;

	assign fill_active  = (fill_req.command != dcache_pkg::BUS_NONE);
	assign store_active = (store_req.command != dcache_pkg::BUS_NONE);

	// fills go first so a miss is not stalled behind write-back traffic.
	always_comb begin
		if (hold) begin
			sel_fill = hold_fill; // a refused request keeps the bus.
		end else if (store_active && (full || !fill_active)) begin
			sel_fill = 1'b0;
		end else begin
			sel_fill = 1'b1;
		end
	end

	assign mem_req        = sel_fill ? fill_req : store_req;
	assign fill_response  = (sel_fill && fill_active) ? mem_rsp_response : '0;
	assign store_response = (!sel_fill && store_active) ? mem_rsp_response : '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			hold      <= 1'b0;
			hold_fill <= 1'b0;
		end else begin
			hold      <= (mem_req.command != dcache_pkg::BUS_NONE) && (mem_rsp_response == '0);
			hold_fill <= sel_fill;
		end
	end

endmodule

// ==== src/dcache_ctrl.sv ====
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_ctrl (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     cpu_req_valid,
	output logic                     cpu_req_ready,
	input  dcache_pkg::cpu_req_t     cpu_req,
	output logic                     cpu_rsp_valid,
	output dcache_pkg::cpu_rsp_t     cpu_rsp,
	output logic [`DC_SET_BITS-1:0]  rd_idx,
	input  dcache_pkg::cache_line_t  rd_line,
	output logic                     wr_en,
	output logic [`DC_SET_BITS-1:0]  wr_idx,
	output dcache_pkg::cache_line_t  wr_line,
	output logic                     evict_valid,
	output dcache_pkg::evict_t       evict,
	input  logic                     retire_full,
	output logic [63:0]              lookup_addr,
	input  logic                     lookup_hit,
	input  logic [63:0]              lookup_data,
	output dcache_pkg::mem_req_t     fill_req,
	input  logic [`BUS_TAG_BITS-1:0] fill_response,
	input  logic [63:0]              mem_data,
	input  logic [`BUS_TAG_BITS-1:0] mem_tag
);

	dcache_pkg::ctrl_state_e  state;
	dcache_pkg::ctrl_state_e  state_next;
	dcache_pkg::cpu_req_t     req_q;
	logic [63:0]              line_q;
	logic [`BUS_TAG_BITS-1:0] bus_tag_q;

	logic [`DC_SET_BITS-1:0] req_idx;
	logic [`DC_TAG_BITS-1:0] req_tag;
	logic is_store;
	logic hit;
	logic fetch_issue;
	logic fill_back;

	assign req_idx     = req_q.addr[`DC_OFFSET_BITS +: `DC_SET_BITS];
	assign req_tag     = req_q.addr[`DC_ADDR_BITS-1 -: `DC_TAG_BITS];
	assign is_store    = (req_q.op == dcache_pkg::OP_STORE);
	assign hit         = rd_line.valid && (rd_line.tag == req_tag);
	assign fetch_issue = (state == dcache_pkg::S_FETCH) && !lookup_hit;
	assign fill_back   = (state == dcache_pkg::S_WAIT) && (mem_tag == bus_tag_q);

	assign cpu_req_ready = (state == dcache_pkg::S_IDLE);
	assign rd_idx        = req_idx;
	assign wr_idx        = req_idx;
	assign lookup_addr   = {{(64-`DC_ADDR_BITS){1'b0}}, req_tag, req_idx,
		{`DC_OFFSET_BITS{1'b0}}};

	// the victim is whatever line currently sits in the set.
	assign evict_valid = (state == dcache_pkg::S_EVICT) && !retire_full;
	assign evict       = '{line: rd_line, idx: req_idx};

	assign fill_req = '{
		command: fetch_issue ? dcache_pkg::BUS_LOAD : dcache_pkg::BUS_NONE,
		addr:    lookup_addr,
		data:    '0
	};

	// a store overwrites the whole word, so fill data is only kept for loads.
	assign wr_en = (state == dcache_pkg::S_FILL) ||
		((state == dcache_pkg::S_LOOKUP) && hit && is_store);
	assign wr_line = '{
		data:  is_store ? req_q.wdata : line_q,
		tag:   req_tag,
		valid: 1'b1,
		dirty: is_store
	};

	always_comb begin
		state_next = state;
		case (state)
			dcache_pkg::S_IDLE: begin
				if (cpu_req_valid) state_next = dcache_pkg::S_LOOKUP;
			end
			dcache_pkg::S_LOOKUP: begin
				if (hit) state_next = dcache_pkg::S_IDLE;
				else if (rd_line.valid && rd_line.dirty) state_next = dcache_pkg::S_EVICT;
				else state_next = dcache_pkg::S_FETCH;
			end
			dcache_pkg::S_EVICT: begin
				if (!retire_full) state_next = dcache_pkg::S_FETCH;
			end
			dcache_pkg::S_FETCH: begin
				if (lookup_hit) state_next = dcache_pkg::S_FILL; // forwarded from the buffer.
				else if (fill_response != '0) state_next = dcache_pkg::S_WAIT;
			end
			dcache_pkg::S_WAIT: begin
				if (fill_back) state_next = dcache_pkg::S_FILL;
			end
			default: state_next = dcache_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state         <= dcache_pkg::S_IDLE;
			cpu_rsp_valid <= 1'b0;
		end else begin
			state         <= state_next;
			cpu_rsp_valid <= ((state == dcache_pkg::S_LOOKUP) && hit) ||
				(state == dcache_pkg::S_FILL);
		end
	end

	always_ff @(posedge clock) begin
		if (cpu_req_valid && cpu_req_ready) req_q <= cpu_req;
		if ((state == dcache_pkg::S_FETCH) && lookup_hit) line_q <= lookup_data;
		if (fill_back) line_q <= mem_data;
		if (fetch_issue && (fill_response != '0)) bus_tag_q <= fill_response;
		if (is_store) begin
			cpu_rsp.rdata <= '0;
		end else begin
			cpu_rsp.rdata <= (state == dcache_pkg::S_FILL) ? line_q : rd_line.data;
		end
	end

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_top (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 cpu_req_valid,
	output logic                 cpu_req_ready,
	input  dcache_pkg::cpu_req_t cpu_req,
	output logic                 cpu_rsp_valid,
	output dcache_pkg::cpu_rsp_t cpu_rsp,
	output dcache_pkg::mem_req_t mem_req,
	input  dcache_pkg::mem_rsp_t mem_rsp
);

	logic [`DC_SET_BITS-1:0]  rd_idx;
	logic [`DC_SET_BITS-1:0]  wr_idx;
	dcache_pkg::cache_line_t  rd_line;
	dcache_pkg::cache_line_t  wr_line;
	logic                     wr_en;
	logic                     evict_valid;
	dcache_pkg::evict_t       evict;
	logic                     retire_full;
	logic [63:0]              lookup_addr;
	logic                     lookup_hit;
	logic [63:0]              lookup_data;
	dcache_pkg::mem_req_t     fill_req;
	dcache_pkg::mem_req_t     store_req;
	logic [`BUS_TAG_BITS-1:0] fill_response;
	logic [`BUS_TAG_BITS-1:0] store_response;

	dcache_ctrl dcache_ctrl_inst (
		.clock(clock), .reset(reset),
		.cpu_req_valid(cpu_req_valid), .cpu_req_ready(cpu_req_ready), .cpu_req(cpu_req),
		.cpu_rsp_valid(cpu_rsp_valid), .cpu_rsp(cpu_rsp),
		.rd_idx(rd_idx), .rd_line(rd_line),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_line(wr_line),
		.evict_valid(evict_valid), .evict(evict), .retire_full(retire_full),
		.lookup_addr(lookup_addr), .lookup_hit(lookup_hit), .lookup_data(lookup_data),
		.fill_req(fill_req), .fill_response(fill_response),
		.mem_data(mem_rsp.data), .mem_tag(mem_rsp.tag)
	);

	dcache_array dcache_array_inst (
		.clock(clock), .reset(reset),
		.rd_idx(rd_idx), .rd_line(rd_line),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_line(wr_line)
	);

	retire_buffer retire_buffer_inst (
		.clock(clock), .reset(reset),
		.evict_valid(evict_valid), .evict(evict),
		.lookup_addr(lookup_addr), .lookup_hit(lookup_hit), .lookup_data(lookup_data),
		.store_req(store_req), .store_response(store_response), .full(retire_full)
	);

	mem_bus_arbiter mem_bus_arbiter_inst (
		.clock(clock), .reset(reset),
		.fill_req(fill_req), .store_req(store_req), .full(retire_full),
		.fill_response(fill_response), .store_response(store_response),
		.mem_req(mem_req), .mem_rsp_response(mem_rsp.response)
	);

endmodule

// ==== dv/mem_model.sv ====
`timescale 1ns/100ps
`include "dcache_defs.svh"

module mem_model #(
	parameter int LATENCY = 6
) (
	input  logic                 clock,
	input  logic                 reset,
	input  dcache_pkg::mem_req_t mem_req,
	output dcache_pkg::mem_rsp_t mem_rsp
);

	integer                   seed;
	int                       now;
	logic [`BUS_TAG_BITS-1:0] free_tag;
	logic [63:0]              words [logic [63:0]];
	logic [63:0]              return_data [$];
	logic [`BUS_TAG_BITS-1:0] return_tag [$];
	int                       return_due [$];

	// every word starts with a value of its own, so a wrong line never reads back right.
	function automatic logic [63:0] fill_word(input logic [63:0] addr);
		return (addr * 64'h9e37_79b9_7f4a_7c15) ^ {~addr[31:0], addr[63:32]};
	endfunction

	initial begin
		seed    = 32'hd086_3cd2;
		mem_rsp = '0;
	end

	always @(posedge clock) begin
		if (reset) begin
			mem_rsp  <= '0;
			now      = 0;
			free_tag = 1;
			return_data.delete();
			return_tag.delete();
			return_due.delete();
		end else begin
			now = now + 1;
			if ((mem_req.command != dcache_pkg::BUS_NONE) && (mem_rsp.response != '0)) begin
				if (mem_req.command == dcache_pkg::BUS_STORE) begin
					words[mem_req.addr] = mem_req.data;
				end else begin
					return_data.push_back(words.exists(mem_req.addr) ?
						words[mem_req.addr] : fill_word(mem_req.addr));
					return_tag.push_back(mem_rsp.response);
					return_due.push_back(now + LATENCY - 1);
				end
				free_tag = (free_tag == '1) ? 1 : free_tag + 1; // a tag comes back long before it is reused.
			end
			mem_rsp.response <= (($random(seed) & 1) != 0) ? free_tag : '0;
			if ((return_due.size() != 0) && (return_due[0] == now)) begin
				mem_rsp.tag  <= return_tag.pop_front();
				mem_rsp.data <= return_data.pop_front();
				void'(return_due.pop_front());
			end else begin
				mem_rsp.tag  <= '0;
				mem_rsp.data <= '0;
			end
		end
	end

endmodule

// ==== dv/dcache_tb.sv ====
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_tb;

	localparam int RANDOM_REQUESTS = 300;
	localparam int REQUESTS        = RANDOM_REQUESTS + 20;
	localparam int CYCLE_LIMIT     = REQUESTS * 60 + 500;

	logic                 clock;
	logic                 reset;
	logic                 cpu_req_valid;
	logic                 cpu_req_ready;
	dcache_pkg::cpu_req_t cpu_req;
	logic                 cpu_rsp_valid;
	dcache_pkg::cpu_rsp_t cpu_rsp;
	dcache_pkg::mem_req_t mem_req;
	dcache_pkg::mem_rsp_t mem_rsp;

	integer seed;
	int     cycle;
	int     errors;
	int     tests_run;
	int     tests_failed;
	int     bus_stores;
	int     dirty_evictions;
	int     full_cycles;

	logic [63:0]             shadow [logic [`DC_ADDR_BITS-1:0]];
	logic [`DC_TAG_BITS-1:0] model_tag [`DC_SETS];
	logic [`DC_SETS-1:0]     model_valid;
	logic [`DC_SETS-1:0]     model_dirty;
	logic [63:0]             victim_addr_q [$];
	logic [63:0]             victim_data_q [$];

	initial clock = 1'b0;
	always #4 clock = ~clock;

	dcache_top dcache_top_inst (
		.clock(clock), .reset(reset),
		.cpu_req_valid(cpu_req_valid), .cpu_req_ready(cpu_req_ready), .cpu_req(cpu_req),
		.cpu_rsp_valid(cpu_rsp_valid), .cpu_rsp(cpu_rsp),
		.mem_req(mem_req), .mem_rsp(mem_rsp)
	);

	mem_model mem_model_inst (.clock(clock), .reset(reset), .mem_req(mem_req), .mem_rsp(mem_rsp));

	property request_held;
		@(posedge clock) disable iff (reset)
			((mem_req.command != dcache_pkg::BUS_NONE) && (mem_rsp.response == '0)) |=>
				(mem_req == $past(mem_req));
	endproperty

	assert property (request_held) else begin
		$display("[FAIL] mem_req changed to %h before memory accepted it", mem_req);
		errors++;
	end

	assert property (@(posedge clock) disable iff (reset) cpu_rsp_valid |=> !cpu_rsp_valid)
	else begin
		$display("[FAIL] cpu_rsp_valid: got %h for two cycles in a row", cpu_rsp_valid);
		errors++;
	end

	// write-backs leave the buffer in eviction order.
	always @(posedge clock) begin
		if (!reset && (mem_req.command == dcache_pkg::BUS_STORE) && (mem_rsp.response != '0)) begin
			bus_stores++;
			if (victim_addr_q.size() == 0) begin
				$display("bus store to %h with no dirty eviction behind it", mem_req.addr);
				errors++;
			end else begin
				assert ((mem_req.addr == victim_addr_q[0]) && (mem_req.data == victim_data_q[0]))
				else begin
					$display("[FAIL] mem_req store: got %h/%h, expected %h/%h", mem_req.addr,
						mem_req.data, victim_addr_q[0], victim_data_q[0]);
					errors++;
				end
				void'(victim_addr_q.pop_front());
				void'(victim_data_q.pop_front());
			end
		end
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (dcache_top_inst.retire_full) full_cycles++;
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [63:0] expected_word(input logic [`DC_ADDR_BITS-1:0] addr);
		logic [63:0] wide;
		wide = 64'(addr);
		if (shadow.exists(addr)) return shadow[addr];
		return (wide * 64'h9e37_79b9_7f4a_7c15) ^ {~wide[31:0], wide[63:32]};
	endfunction

	task automatic predict_access(input logic is_store, input logic [`DC_ADDR_BITS-1:0] addr,
			output logic hit);
		logic [`DC_SET_BITS-1:0]  idx;
		logic [`DC_TAG_BITS-1:0]  tag;
		logic [`DC_ADDR_BITS-1:0] victim;
		idx = addr[`DC_OFFSET_BITS +: `DC_SET_BITS];
		tag = addr[`DC_ADDR_BITS-1 -: `DC_TAG_BITS];
		hit = model_valid[idx] && (model_tag[idx] == tag);
		if (!hit) begin
			if (model_valid[idx] && model_dirty[idx]) begin
				victim = {model_tag[idx], idx, {`DC_OFFSET_BITS{1'b0}}};
				victim_addr_q.push_back(64'(victim));
				victim_data_q.push_back(expected_word(victim));
				dirty_evictions++;
			end
			model_valid[idx] = 1'b1;
			model_tag[idx]   = tag;
			model_dirty[idx] = 1'b0;
		end
		if (is_store) model_dirty[idx] = 1'b1;
	endtask

	task automatic access(input logic is_store, input logic [`DC_ADDR_BITS-1:0] addr,
			input logic [63:0] wdata, output logic hit, output int latency);
		logic [63:0] want;
		int          accepted_at;
		predict_access(is_store, addr, hit);
		want = is_store ? 64'h0 : expected_word(addr);
		if (is_store) shadow[addr] = wdata;
		cpu_req_valid <= 1'b1;
		cpu_req       <= '{op: dcache_pkg::cpu_op_e'(is_store), addr: addr, wdata: wdata};
		do @(posedge clock); while (!cpu_req_ready);
		accepted_at = cycle;
		cpu_req_valid <= 1'b0;
		do @(posedge clock); while (!cpu_rsp_valid);
		latency = cycle - accepted_at;
		assert (cpu_rsp.rdata == want) else begin
			$display("[FAIL] cpu_rsp.rdata at %h: got %h, expected %h", addr, cpu_rsp.rdata, want);
			errors++;
		end
	endtask

	task automatic check_hit(input logic hit, input int latency);
		assert (hit && (latency == 2)) else begin
			$display("[FAIL] hit latency: got %h cycles, expected %h", latency, 2);
			errors++;
		end
	endtask

	task automatic drain_and_count();
		int waited;
		waited = 0;
		while ((victim_addr_q.size() != 0) && (waited < 400)) begin
			@(posedge clock);
			waited++;
		end
		assert (bus_stores == dirty_evictions) else begin
			$display("[FAIL] bus store count: got %h, expected %h", bus_stores, dirty_evictions);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
		end
	endtask

	initial begin
		logic                     hit;
		int                       latency;
		int                       errors_before;
		logic [`DC_ADDR_BITS-1:0] addr;
		logic [63:0]              data;
		seed            = 32'hd086_3cd2;
		cycle           = 0;
		errors          = 0;
		tests_run       = 0;
		tests_failed    = 0;
		bus_stores      = 0;
		dirty_evictions = 0;
		full_cycles     = 0;
		model_valid     = '0;
		model_dirty     = '0;
		reset           = 1'b1;
		cpu_req_valid   = 1'b0;
		cpu_req         = '0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		errors_before = errors;
		assert (!cpu_rsp_valid && cpu_req_ready && (mem_req.command == dcache_pkg::BUS_NONE))
		else begin
			$display("[FAIL] after reset: cpu_rsp_valid %h, cpu_req_ready %h, mem_req.command %h",
				cpu_rsp_valid, cpu_req_ready, mem_req.command);
			errors++;
		end
		report_test("reset values", errors_before);

		errors_before = errors;
		access(1'b1, 16'h1230, 64'h0123_4567_89ab_cdef, hit, latency);
		access(1'b0, 16'h1230, '0, hit, latency);
		check_hit(hit, latency);
		access(1'b1, 16'h1230, 64'hfeed_0000_beef_5555, hit, latency);
		check_hit(hit, latency);
		access(1'b0, 16'h1230, '0, hit, latency);
		check_hit(hit, latency);
		report_test("store then load hit", errors_before);

		errors_before = errors;
		access(1'b1, 16'h4a18, 64'h1111_2222_3333_4444, hit, latency);
		access(1'b1, 16'h7b18, 64'h5555_6666_7777_8888, hit, latency); // same set as 4a18.
		drain_and_count();
		report_test("dirty eviction store", errors_before);

		errors_before = errors;
		access(1'b1, 16'h4a18, 64'h9999_aaaa_bbbb_cccc, hit, latency);
		access(1'b0, 16'h7b18, '0, hit, latency); // the line evicted one request ago.
		access(1'b0, 16'h0520, '0, hit, latency);
		access(1'b0, 16'h0620, '0, hit, latency); // clean victim, no write-back.
		drain_and_count();
		report_test("reload and clean eviction", errors_before);

		errors_before = errors;
		for (int i = 0; i < RANDOM_REQUESTS; i++) begin
			addr = {7'h15, 6'($random(seed)), {`DC_OFFSET_BITS{1'b0}}}; // 64 lines.
			data = {$random(seed), $random(seed)};
			access(1'($random(seed)), addr, data, hit, latency);
		end
		drain_and_count();
		report_test($sformatf("random run, retire buffer full for %0d cycles", full_cycles),
			errors_before);

		$display("%0d tests, %0d failed, %0d errors, %0d bus stores, %0d dirty evictions",
			tests_run, tests_failed, errors, bus_stores, dirty_evictions);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== dcache_top.f ====
+incdir+src
src/dcache_pkg.sv
src/dcache_array.sv
src/retire_buffer.sv
src/mem_bus_arbiter.sv
src/dcache_ctrl.sv
src/dcache_top.sv
dv/mem_model.sv
dv/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/dcache_pkg.sv
      - src/dcache_array.sv
      - src/retire_buffer.sv
      - src/mem_bus_arbiter.sv
      - src/dcache_ctrl.sv
      - src/dcache_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/mem_model.sv
      - dv/dcache_tb.sv
